//--- design/acq_config.svh
`ifndef ACQ_CONFIG_SVH
`define ACQ_CONFIG_SVH

//////////////////////////////////////////////////
// fifo sizes
`define ACQ_BURST_FIFO_DEPTH 16
`define ACQ_OUT_FIFO_DEPTH 32

// free entries kept in reserve before selects stop
`define ACQ_OUT_ALMOST_FULL_MARGIN 4

//////////////////////////////////////////////////
// trigger time tag
`define ACQ_TIME_WIDTH 42

`endif

//--- design/acq_format_pkg.sv
`default_nettype none

package acq_format_pkg;

    typedef struct packed {
        logic [11:0] sample_hi;      // newer sample of the pair
        logic        ovr_hi;         // over-range for sample_hi
        logic [11:0] sample_lo;      // older sample
        logic        ovr_lo;         // over-range for sample_lo, bit 0
    } adc_pair_t;                    // 26 bits

    typedef struct packed {
        adc_pair_t dat3;             // newest pair
        adc_pair_t dat2;
        adc_pair_t dat1;
        adc_pair_t dat0;             // oldest pair, lowest bits
    } sample_burst_t;                // 104 bits

    typedef enum logic [3:0] {
        tag_fill_hdr = 4'd1,
        tag_wave_hdr = 4'd2,
        tag_data     = 4'd3,
        tag_checksum = 4'd4
    } content_tag_e;

    typedef struct packed {
        content_tag_e tag;           // content tag, bits 131:128
        logic [127:0] payload;
    } acq_word_t;                    // 132 bits

    // sign-extended data always has 00 or 11 in the top two bits
    localparam logic [1:0] hdr_marker = 2'b01;

endpackage

`default_nettype wire

//--- design/acq_ctrl_pkg.sv
`default_nettype none

package acq_ctrl_pkg;

    typedef enum logic [2:0] {
        st_idle,                     // waiting for fill_start
        st_armed,                    // ready for a trigger or fill_end
        st_wave_hdr,                 // waveform header pending
        st_wave_data,                // popping bursts of one waveform
        st_fill_hdr,                 // fill header pending
        st_checksum                  // checksum pending
    } seq_state_e;

    typedef logic [22:0] burst_count_t;  // burst addresses, fill word count
    typedef logic [22:0] wave_count_t;   // waveforms in a fill

endpackage

`default_nettype wire

//--- design/selftrig_sequencer.sv
`timescale 1ns/1ns
`default_nettype none

module selftrig_sequencer (
    input  wire         clk,
    input  wire         rst_n,
    input  wire         fill_start,
    input  wire         fill_end,
    input  wire         trig,
    input  wire  [13:0] async_num_bursts,
    input  wire         burst_pushed,
    input  wire         burst_empty,
    input  wire         out_almost_full,
    output logic        capture_en,
    output logic        burst_pop,
    output logic        trig_accept,
    output logic        sel_fill_hdr,
    output logic        sel_wave_hdr,
    output logic        sel_data,
    output logic        sel_checksum,
    output logic        checksum_init,
    output acq_ctrl_pkg::burst_count_t wave_start_adr,
    output acq_ctrl_pkg::wave_count_t  wave_num,
    output acq_ctrl_pkg::burst_count_t fill_bursts,
    output logic        fill_busy
);

    acq_ctrl_pkg::seq_state_e   state;
    acq_ctrl_pkg::burst_count_t num_bursts;
    acq_ctrl_pkg::burst_count_t push_count;  // bursts pushed this waveform
    acq_ctrl_pkg::burst_count_t data_count;  // data words selected this waveform
    logic out_ok;
    logic any_sel;
    logic last_data;
    logic end_pending;                       // fill_end seen mid-waveform

    assign num_bursts = {9'd0, async_num_bursts};
    assign out_ok     = !out_almost_full;

    //////////////////////////////////////////////////
    // strobes decoded from state
    assign checksum_init = (state == acq_ctrl_pkg::st_idle) && fill_start;
    assign trig_accept   = (state == acq_ctrl_pkg::st_armed) && trig && !fill_end
                           && !end_pending;      // fill_end wins over trig
    assign sel_wave_hdr  = (state == acq_ctrl_pkg::st_wave_hdr) && out_ok;
    assign burst_pop     = (state == acq_ctrl_pkg::st_wave_data) && !burst_empty && out_ok;
    assign sel_data      = burst_pop;            // one data word per popped burst
    assign sel_fill_hdr  = (state == acq_ctrl_pkg::st_fill_hdr) && out_ok;
    assign sel_checksum  = (state == acq_ctrl_pkg::st_checksum) && out_ok;
    assign any_sel       = sel_fill_hdr | sel_wave_hdr | sel_data | sel_checksum;
    assign last_data     = sel_data && (data_count == num_bursts - 1'b1);
    assign fill_busy     = state != acq_ctrl_pkg::st_idle;

    //////////////////////////////////////////////////
    // fsm and counters
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state          <= acq_ctrl_pkg::st_idle;
            capture_en     <= 1'b0;
            end_pending    <= 1'b0;
            push_count     <= '0;
            data_count     <= '0;
            wave_start_adr <= '0;
            wave_num       <= '0;
            fill_bursts    <= '0;
        end else begin
            case (state)
                acq_ctrl_pkg::st_idle: if (fill_start) begin
                    state       <= acq_ctrl_pkg::st_armed;
                    wave_num    <= '0;                   // new fill
                    fill_bursts <= '0;
                    end_pending <= 1'b0;
                end
                acq_ctrl_pkg::st_armed: if (fill_end || end_pending) begin
                    state       <= acq_ctrl_pkg::st_fill_hdr;
                    end_pending <= 1'b0;
                end else if (trig_accept) begin
                    state          <= acq_ctrl_pkg::st_wave_hdr;
                    capture_en     <= 1'b1;
                    push_count     <= '0;
                    data_count     <= '0;
                    wave_start_adr <= fill_bursts;       // nothing emitted until header
                end
                acq_ctrl_pkg::st_wave_hdr: if (sel_wave_hdr) begin
                    state    <= acq_ctrl_pkg::st_wave_data;
                    wave_num <= wave_num + 1'b1;         // mux sampled the old value
                end
                acq_ctrl_pkg::st_wave_data: if (last_data) state <= acq_ctrl_pkg::st_armed;
                acq_ctrl_pkg::st_fill_hdr: if (sel_fill_hdr) state <= acq_ctrl_pkg::st_checksum;
                acq_ctrl_pkg::st_checksum: if (sel_checksum) state <= acq_ctrl_pkg::st_idle;
                default: state <= acq_ctrl_pkg::st_idle;
            endcase
            if (any_sel) fill_bursts <= fill_bursts + 1'b1;  // every emitted word
            if (sel_data) data_count <= data_count + 1'b1;
            if (capture_en && burst_pushed) begin
                push_count <= push_count + 1'b1;
                if (push_count == num_bursts - 1'b1) capture_en <= 1'b0;  // last burst in
            end
            if (fill_end && (state == acq_ctrl_pkg::st_wave_hdr
                             || state == acq_ctrl_pkg::st_wave_data)) begin
                end_pending <= 1'b1;                     // finish waveform first
            end
        end
    end

endmodule

`default_nettype wire

//--- design/adc_burst_collector.sv
`timescale 1ns/1ns
`default_nettype none

module adc_burst_collector (
    input  wire                             clk,
    input  wire                             rst_n,
    input  wire                             fill_start,
    input  wire acq_format_pkg::adc_pair_t  adc_pair,
    input  wire                             adc_valid,
    input  wire                             capture_en,
    input  wire                             burst_full,
    output acq_format_pkg::sample_burst_t   burst_word,
    output logic                            burst_push,
    output logic                            burst_pushed,
    output logic                            burst_overrun
);

    acq_format_pkg::adc_pair_t [3:0] pairs;  // pairs[0] oldest
    logic [1:0] slot;
    logic [1:0] slot_eff;
    logic       capture_q;
    logic       group_done;                  // four pairs gathered last cycle

    assign slot_eff     = (capture_en && !capture_q) ? 2'd0 : slot;  // restart on rise
    assign burst_word   = acq_format_pkg::sample_burst_t'(pairs);
    assign burst_push   = group_done && !burst_full;
    assign burst_pushed = burst_push;

    always_ff @(posedge clk) begin
        if (adc_valid) pairs[slot_eff] <= adc_pair;
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            slot          <= 2'd0;
            capture_q     <= 1'b0;
            group_done    <= 1'b0;
            burst_overrun <= 1'b0;
        end else begin
            capture_q  <= capture_en;
            group_done <= adc_valid && capture_en && (slot_eff == 2'd3);
            if (adc_valid) slot <= slot_eff + 1'b1;  // wraps after slot 3
            if (fill_start) burst_overrun <= 1'b0;
            else if (group_done && burst_full) burst_overrun <= 1'b1;  // burst lost
        end
    end

endmodule

`default_nettype wire

//--- design/trigger_timestamp.sv
`timescale 1ns/1ns
`include "acq_config.svh"
`default_nettype none

module trigger_timestamp (
    input  wire                              clk,
    input  wire                              rst_n,
    input  wire                              trig_accept,
    output logic [`ACQ_TIME_WIDTH-1:0]       trigger_time
);

    logic [`ACQ_TIME_WIDTH-1:0] time_count;  // free running, wraps

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            time_count   <= '0;
            trigger_time <= '0;
        end else begin
            time_count <= time_count + 1'b1;
            if (trig_accept) trigger_time <= time_count;  // count at the trig cycle
        end
    end

endmodule

`default_nettype wire

//--- design/adc_dat_mux_selftrig.sv
`timescale 1ns/1ns
`include "acq_config.svh"
`default_nettype none

module adc_dat_mux_selftrig (
    input  wire                                 clk,
    input  wire                                 rst_n,
    input  wire acq_format_pkg::sample_burst_t  sample_burst,
    input  wire [11:0]                          channel_tag,
    input  wire [1:0]                           ddr3_range,
    input  wire acq_ctrl_pkg::burst_count_t     fill_bursts,
    input  wire acq_ctrl_pkg::burst_count_t     wave_start_adr,
    input  wire [23:0]                          fill_num,
    input  wire acq_ctrl_pkg::wave_count_t      wave_num,
    input  wire [13:0]                          async_num_bursts,
    input  wire [15:0]                          async_pre_trig,
    input  wire [`ACQ_TIME_WIDTH-1:0]           trigger_time,
    input  wire                                 sel_fill_hdr,
    input  wire                                 sel_wave_hdr,
    input  wire                                 sel_data,
    input  wire                                 sel_checksum,
    input  wire                                 checksum_init,
    output acq_format_pkg::acq_word_t           acq_word,
    output logic                                word_valid
);

    logic [127:0] fill_hdr;
    logic [127:0] wave_hdr;
    logic [127:0] data_word;
    logic [127:0] checksum;
    acq_ctrl_pkg::burst_count_t fill_total;

    // one pair to two 16-bit words, over-range dropped, older sample low
    function automatic logic [31:0] unpack_pair(input acq_format_pkg::adc_pair_t p);
        unpack_pair = {{4{p.sample_hi[11]}}, p.sample_hi, {4{p.sample_lo[11]}}, p.sample_lo};
    endfunction

    assign fill_total = fill_bursts + 23'd2;  // fill header and checksum included

    //////////////////////////////////////////////////
    // header layouts
    always_comb begin
        fill_hdr          = '0;
        fill_hdr[23:0]    = fill_num;
        fill_hdr[25:24]   = ddr3_range;
        fill_hdr[26]      = 1'b0;                     // selftrig format
        fill_hdr[49:27]   = fill_total;
        fill_hdr[63:50]   = async_num_bursts;
        fill_hdr[75:64]   = async_pre_trig[11:0];
        fill_hdr[98:76]   = wave_num;                 // final waveform count
        fill_hdr[102:99]  = async_pre_trig[15:12];
        fill_hdr[121:110] = channel_tag;
        fill_hdr[123]     = 1'b1;                     // self triggered
        fill_hdr[127:126] = acq_format_pkg::hdr_marker;

        wave_hdr          = '0;
        wave_hdr[13:0]    = async_num_bursts;
        wave_hdr[25:14]   = async_pre_trig[13:2];     // pairs to bursts
        wave_hdr[48:26]   = wave_start_adr;
        wave_hdr[71:49]   = wave_num;
        wave_hdr[97:72]   = trigger_time[25:0];
        wave_hdr[109:98]  = channel_tag;
        wave_hdr[125:110] = trigger_time[41:26];
        wave_hdr[127:126] = acq_format_pkg::hdr_marker;
    end

    assign data_word = {unpack_pair(sample_burst.dat3), unpack_pair(sample_burst.dat2),
                        unpack_pair(sample_burst.dat1), unpack_pair(sample_burst.dat0)};

    //////////////////////////////////////////////////
    // running xor checksum, tags excluded
    always_ff @(posedge clk) begin
        if (checksum_init) checksum <= '0;
        else if (sel_fill_hdr) checksum <= checksum ^ fill_hdr;
        else if (sel_wave_hdr) checksum <= checksum ^ wave_hdr;
        else if (sel_data) checksum <= checksum ^ data_word;
    end

    // registered output word
    always_ff @(posedge clk) begin
        if (sel_fill_hdr) acq_word <= {acq_format_pkg::tag_fill_hdr, fill_hdr};
        else if (sel_wave_hdr) acq_word <= {acq_format_pkg::tag_wave_hdr, wave_hdr};
        else if (sel_data) acq_word <= {acq_format_pkg::tag_data, data_word};
        else if (sel_checksum) acq_word <= {acq_format_pkg::tag_checksum, checksum};
    end

    always_ff @(posedge clk) begin
        if (!rst_n) word_valid <= 1'b0;
        else word_valid <= sel_fill_hdr | sel_wave_hdr | sel_data | sel_checksum;
    end

endmodule

`default_nettype wire

//--- design/acq_sync_fifo.sv
`timescale 1ns/1ns
`default_nettype none

module acq_sync_fifo #(
    parameter type payload_t = logic [7:0],
    parameter int  depth     = 16
) (
    input  wire                           clk,
    input  wire                           rst_n,
    input  wire                           push,
    input  wire payload_t                 push_data,
    input  wire                           pop,
    output payload_t                      pop_data,
    output logic                          empty,
    output logic                          full,
    output logic [$clog2(depth+1)-1:0]    free_count
);

    localparam int ptr_w = (depth > 1) ? $clog2(depth) : 1;
    localparam int cnt_w = $clog2(depth + 1);

    payload_t         mem [depth];
    logic [ptr_w-1:0] wr_ptr;
    logic [ptr_w-1:0] rd_ptr;
    logic [cnt_w-1:0] count;                 // occupancy
    logic             do_push;
    logic             do_pop;

    assign do_push    = push && !full;       // push while full dropped
    assign do_pop     = pop && !empty;       // pop while empty ignored
    assign empty      = count == '0;
    assign full       = count == cnt_w'(depth);
    assign free_count = cnt_w'(depth) - count;
    assign pop_data   = mem[rd_ptr];         // fall-through head

    always_ff @(posedge clk) begin
        if (do_push) mem[wr_ptr] <= push_data;
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (do_push) wr_ptr <= (wr_ptr == ptr_w'(depth - 1)) ? '0 : wr_ptr + 1'b1;
            if (do_pop) rd_ptr <= (rd_ptr == ptr_w'(depth - 1)) ? '0 : rd_ptr + 1'b1;
            case ({do_push, do_pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;     // both or neither
            endcase
        end
    end

endmodule

`default_nettype wire

//--- design/selftrig_acq_top.sv
`timescale 1ns/1ns
`include "acq_config.svh"
`default_nettype none

module selftrig_acq_top (
    input  wire                             clk,
    input  wire                             rst_n,
    input  wire acq_format_pkg::adc_pair_t  adc_pair,
    input  wire                             adc_valid,
    input  wire                             fill_start,
    input  wire                             fill_end,
    input  wire                             trig,
    input  wire [23:0]                      fill_num,
    input  wire [1:0]                       ddr3_range,
    input  wire [11:0]                      channel_tag,
    input  wire [13:0]                      async_num_bursts,
    input  wire [15:0]                      async_pre_trig,
    input  wire                             out_rd,
    output acq_format_pkg::acq_word_t       out_word,
    output logic                            out_empty,
    output logic                            fill_busy,
    output logic                            burst_overrun
);

    acq_format_pkg::sample_burst_t burst_in;
    acq_format_pkg::sample_burst_t burst_head;
    acq_format_pkg::acq_word_t     mux_word;
    acq_ctrl_pkg::burst_count_t    wave_start_adr;
    acq_ctrl_pkg::burst_count_t    fill_bursts;
    acq_ctrl_pkg::wave_count_t     wave_num;
    logic [`ACQ_TIME_WIDTH-1:0]    trigger_time;
    logic [$clog2(`ACQ_OUT_FIFO_DEPTH+1)-1:0] out_free;
    logic burst_push, burst_pushed, burst_pop, burst_empty, burst_full;
    logic capture_en, trig_accept, checksum_init, word_valid, out_almost_full;
    logic sel_fill_hdr, sel_wave_hdr, sel_data, sel_checksum;

    assign out_almost_full = out_free <= `ACQ_OUT_ALMOST_FULL_MARGIN;  // room for in-flight words

    selftrig_sequencer i_sequencer (
        .clk, .rst_n, .fill_start, .fill_end, .trig, .async_num_bursts,
        .burst_pushed, .burst_empty, .out_almost_full, .capture_en, .burst_pop,
        .trig_accept, .sel_fill_hdr, .sel_wave_hdr, .sel_data, .sel_checksum,
        .checksum_init, .wave_start_adr, .wave_num, .fill_bursts, .fill_busy
    );

    adc_burst_collector i_collector (
        .clk, .rst_n, .fill_start, .adc_pair, .adc_valid, .capture_en,
        .burst_full, .burst_word(burst_in), .burst_push, .burst_pushed, .burst_overrun
    );

    trigger_timestamp i_timestamp (
        .clk, .rst_n, .trig_accept, .trigger_time
    );

    adc_dat_mux_selftrig i_mux (
        .clk, .rst_n, .sample_burst(burst_head), .channel_tag, .ddr3_range,
        .fill_bursts, .wave_start_adr, .fill_num, .wave_num, .async_num_bursts,
        .async_pre_trig, .trigger_time, .sel_fill_hdr, .sel_wave_hdr, .sel_data,
        .sel_checksum, .checksum_init, .acq_word(mux_word), .word_valid
    );

    ////////////////////////////////////////////////// staged sample bursts
    acq_sync_fifo #(
        .payload_t(acq_format_pkg::sample_burst_t),
        .depth    (`ACQ_BURST_FIFO_DEPTH)
    ) i_burst_fifo (
        .clk, .rst_n, .push(burst_push), .push_data(burst_in), .pop(burst_pop),
        .pop_data(burst_head), .empty(burst_empty), .full(burst_full), .free_count()
    );

    ////////////////////////////////////////////////// finished words to the writer
    acq_sync_fifo #(
        .payload_t(acq_format_pkg::acq_word_t),
        .depth    (`ACQ_OUT_FIFO_DEPTH)
    ) i_out_fifo (
        .clk, .rst_n, .push(word_valid), .push_data(mux_word), .pop(out_rd),
        .pop_data(out_word), .empty(out_empty), .full(), .free_count(out_free)
    );

endmodule

`default_nettype wire

//--- test/tb_clock_gen.sv
`timescale 1ns/1ns
`default_nettype none

module tb_clock_gen (
    output logic clk,
    output logic rst_n
);

    initial clk = 1'b0;
    always #4 clk = ~clk;                    // 8 ns period

    initial begin
        rst_n = 1'b0;
        repeat (10) @(posedge clk);          // reset held for 10 cycles
        rst_n <= 1'b1;
    end

endmodule

`default_nettype wire

//--- test/selftrig_acq_checker.sv
`timescale 1ns/1ns
`default_nettype none

module selftrig_acq_checker (
    input wire clk,
    input wire rst_n,
    input wire capture_en,
    input wire trig_accept,
    input wire out_almost_full,
    input wire sel_fill_hdr,
    input wire sel_wave_hdr,
    input wire sel_data,
    input wire sel_checksum
);

    // one word into the mux per cycle
    a_one_select: assert property (@(posedge clk) disable iff (!rst_n)
        $onehot0({sel_fill_hdr, sel_wave_hdr, sel_data, sel_checksum}))
        else $error("more than one select high in the same cycle");

    a_trig_idle: assert property (@(posedge clk) disable iff (!rst_n)
        trig_accept |-> !capture_en)         // one waveform at a time
        else $error("trigger accepted while capture still running");

    a_back_pressure: assert property (@(posedge clk) disable iff (!rst_n)
        out_almost_full |-> !(sel_fill_hdr | sel_wave_hdr | sel_data | sel_checksum))
        else $error("select issued while output fifo almost full");

endmodule

bind selftrig_sequencer selftrig_acq_checker i_checker (
    .clk(clk), .rst_n(rst_n), .capture_en(capture_en), .trig_accept(trig_accept),
    .out_almost_full(out_almost_full), .sel_fill_hdr(sel_fill_hdr),
    .sel_wave_hdr(sel_wave_hdr), .sel_data(sel_data), .sel_checksum(sel_checksum)
);

`default_nettype wire

//--- test/tb_selftrig_acq.sv
`timescale 1ns/1ns
`default_nettype none

module tb_selftrig_acq;

    typedef struct {
        logic [23:0] fill_num;
        logic [11:0] channel_tag;
        logic [1:0]  ddr3_range;
        logic [13:0] num_bursts;
        logic [15:0] pre_trig;
        int          num_trigs;
        int          trig_gap;                // cycles between real triggers
        bit          hold_rd;                 // stall the reader during triggers
    } fill_row_t;

    logic clk, rst_n, adc_valid, fill_start, fill_end, trig, out_rd;
    logic out_empty, fill_busy, burst_overrun;
    logic [23:0] fill_num;
    logic [1:0]  ddr3_range;
    logic [11:0] channel_tag;
    logic [13:0] async_num_bursts;
    logic [15:0] async_pre_trig;
    acq_format_pkg::adc_pair_t adc_pair;
    acq_format_pkg::acq_word_t out_word;

    fill_row_t rows [4];
    acq_format_pkg::adc_pair_t pair_hist [0:8191];  // pair driven at each cycle
    acq_format_pkg::acq_word_t exp_q [$];
    acq_format_pkg::acq_word_t rx_q [$];
    int trig_cyc [$];
    int cyc = 0;
    int rx_base = 0;
    bit hold_rd = 1'b0;
    int rel_cyc = 0;                          // first edge out of reset
    logic [127:0] model_sum;

    tb_clock_gen i_clock_gen (.clk(clk), .rst_n(rst_n));

    selftrig_acq_top i_selftrig_acq_top (
        .clk, .rst_n, .adc_pair, .adc_valid, .fill_start, .fill_end, .trig, .fill_num,
        .ddr3_range, .channel_tag, .async_num_bursts, .async_pre_trig, .out_rd,
        .out_word, .out_empty, .fill_busy, .burst_overrun
    );

    always @(posedge clk) begin
        if (rst_n && out_rd && !out_empty) rx_q.push_back(out_word);  // word popped
    end

    //////////////////////////////////////////////////
    // reporting and compares
    task automatic stop_run(input string line);
        $display("%s", line);
        $display("Finished with errors");
        $fatal(1, "simulation stopped");
    endtask

    task automatic value_error(input string msg);
        stop_run($sformatf("CHECK FAILED at %0t ns: %s", $time, msg));
    endtask

    task automatic payload_compare(input acq_format_pkg::acq_word_t got,
                                   input acq_format_pkg::acq_word_t exp, input int idx);
        if (got.payload !== exp.payload)
            value_error($sformatf("word %0d payload %h, expected %h", idx, got.payload,
                                  exp.payload));
    endtask

    task automatic tag_compare(input acq_format_pkg::content_tag_e got,
                               input acq_format_pkg::content_tag_e exp, input int idx);
        if (got !== exp) value_error($sformatf("word %0d tag %0d, expected %0d", idx, got, exp));
    endtask

    task automatic count_compare(input acq_ctrl_pkg::burst_count_t got,
                                 input acq_ctrl_pkg::burst_count_t exp, input string what);
        if (got !== exp) value_error($sformatf("%s is %0d, expected %0d", what, got, exp));
    endtask

    task automatic level_compare(input logic got, input logic exp, input string what);
        if (got !== exp) value_error($sformatf("%s is %b, expected %b", what, got, exp));
    endtask

    //////////////////////////////////////////////////
    // stimulus
    task automatic tick();
        logic [31:0] rnd;
        @(posedge clk);
        cyc++;
        rnd = $urandom;
        pair_hist[cyc] = rnd[25:0];
        adc_pair   <= rnd[25:0];
        adc_valid  <= 1'b1;
        out_rd     <= !hold_rd;
        trig       <= 1'b0;                   // pulses last one cycle
        fill_start <= 1'b0;
        fill_end   <= 1'b0;
    endtask

    // reference formats
    function automatic logic [15:0] sext12(input logic [11:0] s);
        return 16'($signed(s));
    endfunction

    function automatic logic [127:0] data_payload(input int first);
        logic [127:0] w;
        for (int i = 0; i < 4; i++) begin
            w[32*i +: 16]      = sext12(pair_hist[first + i].sample_lo);  // older sample low
            w[32*i + 16 +: 16] = sext12(pair_hist[first + i].sample_hi);
        end
        return w;
    endfunction

    function automatic logic [127:0] wave_header(input fill_row_t r, input int adr,
                                                 input int wnum, input logic [41:0] t);
        logic [127:0] h;
        h = '0;
        h[13:0]    = r.num_bursts;
        h[25:14]   = r.pre_trig[13:2];
        h[48:26]   = 23'(adr);
        h[71:49]   = 23'(wnum);
        h[97:72]   = t[25:0];
        h[109:98]  = r.channel_tag;
        h[125:110] = t[41:26];
        h[127:126] = 2'b01;
        return h;
    endfunction

    function automatic logic [127:0] fill_header(input fill_row_t r, input int total);
        logic [127:0] h;
        h = '0;
        h[23:0]    = r.fill_num;
        h[25:24]   = r.ddr3_range;
        h[49:27]   = 23'(total);
        h[63:50]   = r.num_bursts;
        h[75:64]   = r.pre_trig[11:0];
        h[98:76]   = 23'(r.num_trigs);        // waveforms in the fill
        h[102:99]  = r.pre_trig[15:12];
        h[121:110] = r.channel_tag;
        h[123]     = 1'b1;
        h[127:126] = 2'b01;
        return h;
    endfunction

    task automatic expect_word(input acq_format_pkg::content_tag_e tag,
                               input logic [127:0] payload);
        exp_q.push_back({tag, payload});
        model_sum = model_sum ^ payload;
    endtask

    task automatic check_fill(input fill_row_t r);
        acq_format_pkg::acq_word_t got;
        logic [41:0] t;
        int n_exp;
        int waited;
        n_exp = r.num_trigs * (int'(r.num_bursts) + 1) + 2;
        waited = 0;
        while (rx_q.size() < rx_base + n_exp) begin
            if (waited == 3000) stop_run("timeout waiting for output words of the fill");
            tick();
            waited++;
        end
        repeat (8) tick();                    // extra words would show up here
        if (rx_q.size() != rx_base + n_exp)
            value_error($sformatf("%0d words in fill, expected %0d", rx_q.size() - rx_base, n_exp));
        exp_q.delete();
        model_sum = '0;
        for (int i = 0; i < r.num_trigs; i++) begin
            t = 42'(trig_cyc[i] + 1 - rel_cyc);  // trig sampled on the edge after it is driven
            expect_word(acq_format_pkg::tag_wave_hdr, wave_header(r, exp_q.size(), i, t));
            for (int b = 0; b < int'(r.num_bursts); b++)
                expect_word(acq_format_pkg::tag_data, data_payload(trig_cyc[i] + 1 + 4 * b));
        end
        expect_word(acq_format_pkg::tag_fill_hdr, fill_header(r, exp_q.size() + 2));
        exp_q.push_back({acq_format_pkg::tag_checksum, model_sum});
        foreach (exp_q[i]) begin
            got = rx_q[rx_base + i];
            tag_compare(got.tag, exp_q[i].tag, i);
            if (got.tag == acq_format_pkg::tag_wave_hdr)
                count_compare(got.payload[48:26], 23'(i), "waveform start address");
            if (got.tag == acq_format_pkg::tag_fill_hdr)
                count_compare(got.payload[49:27], 23'(n_exp), "fill word count");
            payload_compare(got, exp_q[i], i);
        end
        level_compare(burst_overrun, 1'b0, "burst_overrun in a fill that fits");
        rx_base += n_exp;
        trig_cyc.delete();
    endtask

    //////////////////////////////////////////////////
    // fills applied from the table
    initial begin
        fill_row_t r;
        int waited;
        void'($urandom(32'h7edd_39e3));
        adc_pair <= '0;
        adc_valid <= 1'b0;
        fill_start <= 1'b0;
        fill_end <= 1'b0;
        trig <= 1'b0;
        out_rd <= 1'b0;
        fill_num <= '0;
        ddr3_range <= '0;
        channel_tag <= '0;
        async_num_bursts <= '0;
        async_pre_trig <= '0;
        rows[0] = '{24'h000123, 12'h5a1, 2'd1, 14'd2, 16'h0104, 3, 20, 1'b0};
        rows[1] = '{24'h00abcd, 12'hfff, 2'd3, 14'd5, 16'hc3f8, 2, 32, 1'b0};
        rows[2] = '{24'h7fe001, 12'h042, 2'd2, 14'd12, 16'h8002, 3, 60, 1'b1};
        rows[3] = '{24'h000004, 12'h800, 2'd0, 14'd1, 16'h0000, 0, 10, 1'b0};
        waited = 0;
        while (rst_n !== 1'b1) begin
            if (waited == 50) stop_run("timeout waiting for reset release");
            tick();
            waited++;
        end
        rel_cyc = cyc;                        // time counter reads zero before this edge
        level_compare(out_empty, 1'b1, "out_empty after reset");
        level_compare(fill_busy, 1'b0, "fill_busy after reset");
        for (int ri = 0; ri < 4; ri++) begin
            r = rows[ri];
            hold_rd = r.hold_rd;
            tick();
            fill_num         <= r.fill_num;
            channel_tag      <= r.channel_tag;
            ddr3_range       <= r.ddr3_range;
            async_num_bursts <= r.num_bursts;
            async_pre_trig   <= r.pre_trig;
            fill_start       <= 1'b1;
            tick();
            for (int i = 0; i < r.num_trigs; i++) begin
                tick();
                trig <= 1'b1;
                trig_cyc.push_back(cyc);
                repeat (3) tick();
                trig <= 1'b1;                 // lands during capture, ignored
                repeat (r.trig_gap - 4) tick();
            end
            hold_rd = 1'b0;                   // release the stalled reader
            tick();
            fill_end <= 1'b1;
            level_compare(fill_busy, 1'b1, "fill_busy during the fill");
            waited = 0;
            do begin
                if (waited == 3000) stop_run("timeout waiting for the fill to finish");
                tick();
                waited++;
            end while (fill_busy !== 1'b0);
            check_fill(r);
        end
        $display("Finished with no errors");
        $finish;
    end

endmodule

`default_nettype wire

//--- files.f
+incdir+design
design/acq_format_pkg.sv
design/acq_ctrl_pkg.sv
design/selftrig_sequencer.sv
design/adc_burst_collector.sv
design/trigger_timestamp.sv
design/adc_dat_mux_selftrig.sv
design/acq_sync_fifo.sv
design/selftrig_acq_top.sv
test/tb_clock_gen.sv
test/selftrig_acq_checker.sv
test/tb_selftrig_acq.sv

//--- run_sim.sh
#!/bin/sh
# build and run the selftrig acquisition testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -j 0 \
    --top-module tb_selftrig_acq \
    -f files.f \
    --Mdir obj_dir -o tb_sim
status=$?
if [ $status -ne 0 ]; then
    echo "compile failed with status $status"
    exit $status
fi

./obj_dir/tb_sim
status=$?
if [ $status -ne 0 ]; then
    echo "simulation failed with status $status"
    exit $status
fi

exit 0
